// File: files.f
+incdir+hdl
hdl/z_engine_pkg.sv
hdl/z_step_feeder.sv
hdl/z_mac_lane.sv
hdl/z_row_writeback.sv
hdl/z_buffer_scm.sv
hdl/z_engine_top.sv
testbench/z_engine_assertions.sv
testbench/tb_z_engine.sv

// File: hdl/z_buffer_scm.sv
`timescale 1ns/1ps
`include "z_engine_params.svh"

module z_buffer_scm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   row_write_en_i,
  input  logic                   col_write_en_i,
  input  z_engine_pkg::row_idx_t row_write_addr_i,
  input  z_engine_pkg::col_idx_t col_write_addr_i,
  input  z_engine_pkg::row_vec_t row_wdata_i,
  input  z_engine_pkg::col_vec_t col_wdata_i,
  input  logic                   row_read_en_i,
  input  logic                   col_read_en_i,
  input  z_engine_pkg::row_idx_t row_read_addr_i,
  input  z_engine_pkg::col_idx_t col_read_addr_i,
  output z_engine_pkg::row_vec_t row_rdata_o,
  output z_engine_pkg::col_vec_t col_rdata_o
);

  import z_engine_pkg::*;

  row_vec_t            buffer_q [`Z_ROWS];
  row_idx_t            row_read_addr_q;
  col_idx_t            col_read_addr_q;
  logic [`Z_ROWS-1:0]  row_hit;
  logic [`Z_COLS-1:0]  col_hit;

  always_ff @(posedge clk_i or negedge rst_ni) begin : row_raddr_reg
    if (!rst_ni) begin
      row_read_addr_q <= '0;
    end else begin
      if (clear_i) begin
        row_read_addr_q <= '0;
      end else if (row_read_en_i) begin
        row_read_addr_q <= row_read_addr_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : col_raddr_reg
    if (!rst_ni) begin
      col_read_addr_q <= '0;
    end else begin
      if (clear_i) begin
        col_read_addr_q <= '0;
      end else if (col_read_en_i) begin
        col_read_addr_q <= col_read_addr_i;
      end
    end
  end

  for (genvar r = 0; r < `Z_ROWS; r++) begin : gen_row_hit
    assign row_hit[r] = row_write_en_i && (row_write_addr_i == row_idx_t'(r));
  end

  for (genvar c = 0; c < `Z_COLS; c++) begin : gen_col_hit
    assign col_hit[c] = col_write_en_i && (col_write_addr_i == col_idx_t'(c));
  end

  // Each element takes the row data when its row is addressed, otherwise
  // the column data when its column is
  for (genvar r = 0; r < `Z_ROWS; r++) begin : gen_rows
    for (genvar c = 0; c < `Z_COLS; c++) begin : gen_cols
      always_ff @(posedge clk_i or negedge rst_ni) begin : element_reg
        if (!rst_ni) begin
          buffer_q[r][c] <= '0;
        end else begin
          if (clear_i) begin
            buffer_q[r][c] <= '0;
          end else if (row_hit[r]) begin
            buffer_q[r][c] <= row_wdata_i[c];
          end else if (col_hit[c]) begin
            buffer_q[r][c] <= col_wdata_i[r];
          end
        end
      end
    end
  end

  for (genvar r = 0; r < `Z_ROWS; r++) begin : gen_col_read
    assign col_rdata_o[r] = buffer_q[r][col_read_addr_q];
  end

  assign row_rdata_o = buffer_q[row_read_addr_q];

endmodule : z_buffer_scm

// File: hdl/z_engine_params.svh
`ifndef Z_ENGINE_PARAMS_SVH
`define Z_ENGINE_PARAMS_SVH

// Width of one tile element, arithmetic wraps at this width
`define Z_WORD_WIDTH 16

// Tile geometry, both dimensions must be powers of two
`define Z_ROWS 4
`define Z_COLS 4

`endif

// File: hdl/z_engine_pkg.sv
`include "z_engine_params.svh"

package z_engine_pkg;

  typedef logic [`Z_WORD_WIDTH-1:0]        word_t;
  typedef logic [$clog2(`Z_ROWS)-1:0]      row_idx_t;
  typedef logic [$clog2(`Z_COLS)-1:0]      col_idx_t;

  // Word c of a row sits at index c, word r of a column at index r
  typedef logic [`Z_COLS-1:0][`Z_WORD_WIDTH-1:0] row_vec_t;
  typedef logic [`Z_ROWS-1:0][`Z_WORD_WIDTH-1:0] col_vec_t;

  typedef logic [`Z_ROWS-1:0]              row_mask_t;

  // One accumulation step as sent by the host
  typedef struct packed {
    row_idx_t row;
    word_t    x;
    row_vec_t w;
    logic     first;
    logic     last;
  } step_t;

  // Step after registration in the feeder
  typedef struct packed {
    row_idx_t row;
    word_t    x;
    row_vec_t w;
    logic     first;
    logic     last;
  } lane_cmd_t;

endpackage : z_engine_pkg

// File: hdl/z_engine_top.sv
`timescale 1ns/1ps
`include "z_engine_params.svh"

module z_engine_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    bias_wr_en_i,
  input  z_engine_pkg::col_idx_t  bias_col_i,
  input  z_engine_pkg::col_vec_t  bias_col_data_i,
  input  logic                    step_valid_i,
  input  z_engine_pkg::step_t     step_i,
  input  logic                    rd_en_i,
  input  z_engine_pkg::col_idx_t  rd_col_i,
  output z_engine_pkg::col_vec_t  rd_data_o,
  output logic                    row_done_o,
  output z_engine_pkg::row_idx_t  row_done_idx_o,
  output z_engine_pkg::row_mask_t tile_done_o
);

  import z_engine_pkg::*;

  logic               row_rd_en;
  row_idx_t           row_rd_addr;
  row_vec_t           row_rdata;
  logic               cmd_valid;
  lane_cmd_t          cmd;
  logic [`Z_COLS-1:0] lane_valid;
  row_vec_t           lane_result;
  logic               row_wr_en;
  row_idx_t           row_wr_addr;
  row_vec_t           row_wr_data;

  z_step_feeder i_feeder (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .clear_i       ( clear_i      ),
    .step_valid_i  ( step_valid_i ),
    .step_i        ( step_i       ),
    .bias_rd_en_o  ( row_rd_en    ),
    .bias_rd_row_o ( row_rd_addr  ),
    .cmd_valid_o   ( cmd_valid    ),
    .cmd_o         ( cmd          )
  );

  // Lane c owns column c of the tile
  for (genvar c = 0; c < `Z_COLS; c++) begin : gen_lanes
    z_mac_lane i_lane (
      .clk_i          ( clk_i          ),
      .rst_ni         ( rst_ni         ),
      .clear_i        ( clear_i        ),
      .cmd_valid_i    ( cmd_valid      ),
      .cmd_x_i        ( cmd.x          ),
      .cmd_w_i        ( cmd.w[c]       ),
      .cmd_first_i    ( cmd.first      ),
      .cmd_last_i     ( cmd.last       ),
      .bias_i         ( row_rdata[c]   ),
      .result_valid_o ( lane_valid[c]  ),
      .result_o       ( lane_result[c] )
    );
  end

  z_row_writeback i_writeback (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .cmd_valid_i    ( cmd_valid      ),
    .cmd_last_i     ( cmd.last       ),
    .cmd_row_i      ( cmd.row        ),
    .lane_valid_i   ( lane_valid[0]  ),
    .lane_result_i  ( lane_result    ),
    .row_wr_en_o    ( row_wr_en      ),
    .row_wr_addr_o  ( row_wr_addr    ),
    .row_wr_data_o  ( row_wr_data    ),
    .row_done_o     ( row_done_o     ),
    .row_done_idx_o ( row_done_idx_o ),
    .tile_done_o    ( tile_done_o    )
  );

  z_buffer_scm i_buffer (
    .clk_i            ( clk_i           ),
    .rst_ni           ( rst_ni          ),
    .clear_i          ( clear_i         ),
    .row_write_en_i   ( row_wr_en       ),
    .col_write_en_i   ( bias_wr_en_i    ),
    .row_write_addr_i ( row_wr_addr     ),
    .col_write_addr_i ( bias_col_i      ),
    .row_wdata_i      ( row_wr_data     ),
    .col_wdata_i      ( bias_col_data_i ),
    .row_read_en_i    ( row_rd_en       ),
    .col_read_en_i    ( rd_en_i         ),
    .row_read_addr_i  ( row_rd_addr     ),
    .col_read_addr_i  ( rd_col_i        ),
    .row_rdata_o      ( row_rdata       ),
    .col_rdata_o      ( rd_data_o       )
  );

endmodule : z_engine_top

// File: hdl/z_mac_lane.sv
`timescale 1ns/1ps

module z_mac_lane (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 cmd_valid_i,
  input  z_engine_pkg::word_t  cmd_x_i,
  input  z_engine_pkg::word_t  cmd_w_i,
  input  logic                 cmd_first_i,
  input  logic                 cmd_last_i,
  input  z_engine_pkg::word_t  bias_i,
  output logic                 result_valid_o,
  output z_engine_pkg::word_t  result_o
);

  import z_engine_pkg::*;

  word_t product;
  word_t acc_d;
  word_t acc_q;
  logic  result_valid_q;

  // Only the low word of the product is kept
  assign product = cmd_x_i * cmd_w_i;

  // A first step restarts the sum from the bias fetched for this row
  assign acc_d = (cmd_first_i ? bias_i : acc_q) + product;

  always_ff @(posedge clk_i or negedge rst_ni) begin : acc_reg
    if (!rst_ni) begin
      acc_q <= '0;
    end else begin
      if (clear_i) begin
        acc_q <= '0;
      end else if (cmd_valid_i) begin
        acc_q <= acc_d;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : result_valid_reg
    if (!rst_ni) begin
      result_valid_q <= 1'b0;
    end else begin
      if (clear_i) begin
        result_valid_q <= 1'b0;
      end else begin
        result_valid_q <= cmd_valid_i & cmd_last_i;
      end
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = acc_q;

endmodule : z_mac_lane

// File: hdl/z_row_writeback.sv
`timescale 1ns/1ps

module z_row_writeback (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   cmd_valid_i,
  input  logic                   cmd_last_i,
  input  z_engine_pkg::row_idx_t cmd_row_i,
  input  logic                   lane_valid_i,
  input  z_engine_pkg::row_vec_t lane_result_i,
  output logic                   row_wr_en_o,
  output z_engine_pkg::row_idx_t row_wr_addr_o,
  output z_engine_pkg::row_vec_t row_wr_data_o,
  output logic                   row_done_o,
  output z_engine_pkg::row_idx_t row_done_idx_o,
  output z_engine_pkg::row_mask_t tile_done_o
);

  import z_engine_pkg::*;

  row_idx_t  pend_row_q;
  logic      row_done_q;
  row_idx_t  row_done_idx_q;
  row_mask_t tile_done_q;

  // The lanes finish one cycle after the last command, so a single
  // register is enough even for back to back one-step rows
  always_ff @(posedge clk_i or negedge rst_ni) begin : pend_row_reg
    if (!rst_ni) begin
      pend_row_q <= '0;
    end else begin
      if (clear_i) begin
        pend_row_q <= '0;
      end else if (cmd_valid_i && cmd_last_i) begin
        pend_row_q <= cmd_row_i;
      end
    end
  end

  assign row_wr_en_o   = lane_valid_i;
  assign row_wr_addr_o = pend_row_q;
  assign row_wr_data_o = lane_result_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : done_regs
    if (!rst_ni) begin
      row_done_q     <= 1'b0;
      row_done_idx_q <= '0;
      tile_done_q    <= '0;
    end else begin
      if (clear_i) begin
        row_done_q     <= 1'b0;
        row_done_idx_q <= '0;
        tile_done_q    <= '0;
      end else begin
        row_done_q <= lane_valid_i;
        if (lane_valid_i) begin
          row_done_idx_q          <= pend_row_q;
          tile_done_q[pend_row_q] <= 1'b1;
        end
      end
    end
  end

  assign row_done_o     = row_done_q;
  assign row_done_idx_o = row_done_idx_q;
  assign tile_done_o    = tile_done_q;

endmodule : z_row_writeback

// File: hdl/z_step_feeder.sv
`timescale 1ns/1ps

module z_step_feeder (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    step_valid_i,
  input  z_engine_pkg::step_t     step_i,
  output logic                    bias_rd_en_o,
  output z_engine_pkg::row_idx_t  bias_rd_row_o,
  output logic                    cmd_valid_o,
  output z_engine_pkg::lane_cmd_t cmd_o
);

  import z_engine_pkg::*;

  logic      cmd_valid_q;
  lane_cmd_t cmd_d;
  lane_cmd_t cmd_q;

  always_comb begin : build_cmd
    cmd_d.row   = step_i.row;
    cmd_d.x     = step_i.x;
    cmd_d.w     = step_i.w;
    cmd_d.first = step_i.first;
    cmd_d.last  = step_i.last;
  end

  // The buffer registers this address at the same edge as the command,
  // so the bias row is on row_rdata when the lanes see the first step
  assign bias_rd_en_o  = step_valid_i & step_i.first;
  assign bias_rd_row_o = step_i.row;

  always_ff @(posedge clk_i or negedge rst_ni) begin : cmd_valid_reg
    if (!rst_ni) begin
      cmd_valid_q <= 1'b0;
    end else begin
      if (clear_i) begin
        cmd_valid_q <= 1'b0;
      end else begin
        cmd_valid_q <= step_valid_i;
      end
    end
  end

  // Payload only moves on a valid step
  always_ff @(posedge clk_i) begin : cmd_payload_reg
    if (step_valid_i) begin
      cmd_q <= cmd_d;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = cmd_q;

endmodule : z_step_feeder

// File: testbench/tb_z_engine.sv
`timescale 1ns/1ps
`include "z_engine_params.svh"

module tb_z_engine;

  import z_engine_pkg::*;

  localparam time CLK_PERIOD = 10;

  logic      clk_i;
  logic      rst_ni;
  logic      clear_i;
  logic      bias_wr_en_i;
  col_idx_t  bias_col_i;
  col_vec_t  bias_col_data_i;
  logic      step_valid_i;
  step_t     step_i;
  logic      rd_en_i;
  col_idx_t  rd_col_i;
  col_vec_t  rd_data_o;
  logic      row_done_o;
  row_idx_t  row_done_idx_o;
  row_mask_t tile_done_o;

  logic [15:0] lfsr_q = 16'd9713;
  word_t       model_z [`Z_ROWS][`Z_COLS];
  row_mask_t   model_mask;
  row_idx_t    exp_rows [$];
  time         last_times [$];
  row_idx_t    done_rows [$];
  time         done_times [$];

  z_engine_top i_dut (.*);

  bind z_engine_top z_engine_assertions i_assertions (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .bias_wr_en_i   ( bias_wr_en_i   ),
    .row_wr_en_i    ( row_wr_en      ),
    .row_done_i     ( row_done_o     ),
    .row_done_idx_i ( row_done_idx_o ),
    .tile_done_i    ( tile_done_o    )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(CLK_PERIOD * 5000);
    fail_plain("Simulation ran past its time limit");
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  task automatic fail_value(input string msg);
    $display("FAILED at %0d ns: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic fail_plain(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Stopped on a test failure");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s: got %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_col(input col_vec_t got, input col_vec_t exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s: got %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_mask(input row_mask_t got, input row_mask_t exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s: got %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_row(input row_idx_t got, input row_idx_t exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s: got %0d, expected %0d", what, got, exp));
    end
  endtask

  always @(negedge clk_i) begin : done_monitor
    if (rst_ni && row_done_o) begin
      done_rows.push_back(row_done_idx_o);
      done_times.push_back($time);
    end
  end

  always @(negedge clk_i) begin : assertion_monitor
    if (i_dut.i_assertions.fail_count != 0) begin
      fail_plain("A bound assertion on the DUT failed");
    end
  end

  task automatic clear_model();
    int r;
    int c;
    for (r = 0; r < `Z_ROWS; r++) begin
      for (c = 0; c < `Z_COLS; c++) begin
        model_z[r][c] = '0;
      end
    end
    model_mask = '0;
  endtask

  task automatic clear_queues();
    exp_rows.delete();
    last_times.delete();
    done_rows.delete();
    done_times.delete();
  endtask

  task automatic write_bias(input col_idx_t c, input col_vec_t data);
    int r;
    @(posedge clk_i);
    bias_wr_en_i    <= 1'b1;
    bias_col_i      <= c;
    bias_col_data_i <= data;
    for (r = 0; r < `Z_ROWS; r++) begin
      model_z[r][c] = data[r];
    end
    @(posedge clk_i);
    bias_wr_en_i <= 1'b0;
  endtask

  task automatic load_random_bias();
    col_vec_t data;
    int       r;
    int       c;
    for (c = 0; c < `Z_COLS; c++) begin
      for (r = 0; r < `Z_ROWS; r++) begin
        data[r] = word_t'(rand_bits(16));
      end
      write_bias(col_idx_t'(c), data);
    end
  endtask

  // The address is taken at the edge after the strobe, data is sampled mid-cycle
  task automatic read_col(input col_idx_t c);
    @(posedge clk_i);
    rd_en_i  <= 1'b1;
    rd_col_i <= c;
    @(posedge clk_i);
    rd_en_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic check_tile();
    int r;
    int c;
    for (c = 0; c < `Z_COLS; c++) begin
      read_col(col_idx_t'(c));
      for (r = 0; r < `Z_ROWS; r++) begin
        check_word(rd_data_o[r], model_z[r][c], $sformatf("Z[%0d][%0d]", r, c));
      end
    end
  endtask

  // Steps go out on consecutive cycles, the model keeps Y + X*W per row
  task automatic send_row(input row_idx_t row, input int steps);
    step_t    s;
    row_vec_t acc;
    int       i;
    int       c;
    for (c = 0; c < `Z_COLS; c++) begin
      acc[c] = model_z[row][c];
    end
    for (i = 0; i < steps; i++) begin
      s.row   = row;
      s.x     = word_t'(rand_bits(16));
      s.first = (i == 0);
      s.last  = (i == steps - 1);
      for (c = 0; c < `Z_COLS; c++) begin
        s.w[c] = word_t'(rand_bits(16));
        acc[c] = acc[c] + s.x * s.w[c];
      end
      @(posedge clk_i);
      step_valid_i <= 1'b1;
      step_i       <= s;
      if (s.last) begin
        exp_rows.push_back(row);
        last_times.push_back($time);
      end
    end
    for (c = 0; c < `Z_COLS; c++) begin
      model_z[row][c] = acc[c];
    end
    model_mask[row] = 1'b1;
  endtask

  task automatic end_steps();
    @(posedge clk_i);
    step_valid_i <= 1'b0;
  endtask

  // A pulse is seen mid-cycle three cycles after the edge that drove the last step
  task automatic wait_rows_done(input int count);
    int cycles;
    int i;
    cycles = 0;
    while (done_rows.size() < count) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 40) begin
        fail_plain("Timeout while waiting for row_done_o");
      end
    end
    for (i = 0; i < count; i++) begin
      check_row(done_rows[i], exp_rows[i], $sformatf("row_done_idx_o of pulse %0d", i));
      if (done_times[i] != last_times[i] + 3 * CLK_PERIOD + CLK_PERIOD / 2) begin
        fail_value($sformatf("row %0d done at %0t, last step at %0t",
                             exp_rows[i], done_times[i], last_times[i]));
      end
    end
  endtask

  task automatic test_reset();
    @(negedge clk_i);
    check_col(rd_data_o, '0, "rd_data_o after reset");
    check_mask(tile_done_o, '0, "tile_done_o after reset");
    if (row_done_o !== 1'b0) begin
      fail_value("row_done_o high after reset");
    end
    check_tile();
  endtask

  task automatic test_bias_load();
    col_vec_t written [`Z_COLS];
    int       r;
    int       c;
    for (c = 0; c < `Z_COLS; c++) begin
      for (r = 0; r < `Z_ROWS; r++) begin
        written[c][r] = word_t'(rand_bits(16));
      end
      write_bias(col_idx_t'(c), written[c]);
    end
    for (c = `Z_COLS - 1; c >= 0; c--) begin
      read_col(col_idx_t'(c));
      check_col(rd_data_o, written[c], $sformatf("bias column %0d", c));
    end
  endtask

  task automatic test_single_row();
    row_idx_t row;
    clear_queues();
    load_random_bias();
    row = row_idx_t'(rand_bits(2));
    send_row(row, 2 + int'(rand_bits(2)));
    end_steps();
    wait_rows_done(1);
    check_mask(tile_done_o, model_mask, "tile_done_o after one row");
    check_tile();
  endtask

  task automatic test_full_tile();
    clear_queues();
    load_random_bias();
    send_row(0, 2 + int'(rand_bits(2)));
    send_row(1, 1);
    send_row(2, 2 + int'(rand_bits(2)));
    send_row(3, 1 + int'(rand_bits(2)));
    end_steps();
    wait_rows_done(4);
    check_mask(tile_done_o, '1, "tile_done_o after full tile");
    check_tile();
  endtask

  task automatic test_clear();
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    clear_model();
    @(negedge clk_i);
    check_mask(tile_done_o, '0, "tile_done_o after clear");
    check_tile();
    // Nothing reloads the bias, so this row starts from zero
    clear_queues();
    send_row(row_idx_t'(rand_bits(2)), 3);
    end_steps();
    wait_rows_done(1);
    check_mask(tile_done_o, model_mask, "tile_done_o after clear and one row");
    check_tile();
  endtask

  initial begin : main
    rst_ni          = 1'b0;
    clear_i         = 1'b0;
    bias_wr_en_i    = 1'b0;
    bias_col_i      = '0;
    bias_col_data_i = '0;
    step_valid_i    = 1'b0;
    step_i          = '0;
    rd_en_i         = 1'b0;
    rd_col_i        = '0;
    clear_model();
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset();
    test_bias_load();
    test_single_row();
    test_full_tile();
    test_clear();
    repeat (2) @(negedge clk_i);
    if (i_dut.i_assertions.fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "Bound assertions reported failures");
    end
  end

endmodule : tb_z_engine

// File: testbench/z_engine_assertions.sv
`timescale 1ns/1ps

module z_engine_assertions (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    clear_i,
  input logic                    bias_wr_en_i,
  input logic                    row_wr_en_i,
  input logic                    row_done_i,
  input z_engine_pkg::row_idx_t  row_done_idx_i,
  input z_engine_pkg::row_mask_t tile_done_i
);

  int unsigned fail_count = 0;

  // Back to back pulses are fine when they belong to different rows
  row_done_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    row_done_i |=> !(row_done_i && $stable(row_done_idx_i))
  ) else begin
    $error("row_done_o stayed high for the same row");
    fail_count++;
  end

  tile_done_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !clear_i |=> ((tile_done_i & $past(tile_done_i)) == $past(tile_done_i))
  ) else begin
    $error("tile_done_o lost a bit without clear_i");
    fail_count++;
  end

  no_bias_during_writeback: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(bias_wr_en_i && row_wr_en_i)
  ) else begin
    $error("bias write collided with a row writeback");
    fail_count++;
  end

endmodule : z_engine_assertions
